//--- exPkg.sv
`default_nettype none

package exPkg;

	typedef logic [5:0] regId_t;	// GPR index
	typedef logic [63:0] word_t;	// Data path word
	typedef logic [65:0] aluRes_t;	// Flags in 65:64, value in 63:0

	// Micro-command held in opUCmd[5:0]
	typedef enum logic [5:0] {
		NOP = 6'h00,	// Nothing to complete
		MOV_RM = 6'h01,	// Store Rm to memory
		MOV_MR = 6'h02,	// Load memory into Rm
		ALU3 = 6'h03,	// Three-operand ALU op
		ALUCMP = 6'h04,	// Compare, flags only
		MUL3 = 6'h05	// 32x32 multiply
	} uCmd_t;

	// Predicate held in opUCmd[7:6]
	typedef enum logic [1:0] {
		ALWAYS = 2'b00,	// Unconditional
		NEVER = 2'b01,	// Squashed
		IF_T = 2'b10,	// Run when SR.T set
		IF_F = 2'b11	// Run when SR.T clear
	} predMode_t;

endpackage

`default_nettype wire

//--- memPkg.sv
`default_nettype none

package memPkg;

	typedef logic [15:0] memAddr_t;	// Word address

	// Status returned on every memory bus
	typedef enum logic [1:0] {
		READY = 2'b00,	// Idle, no result
		DONE = 2'b01,	// Access complete, data valid
		HOLD = 2'b10,	// Still in progress
		FAULT = 2'b11	// Address out of range
	} memOk_t;

endpackage

`default_nettype wire

//--- memBusIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memBusIf;

	logic req;	// Access request level
	logic we;	// Write when set
	memPkg::memAddr_t addr;	// Word address
	exPkg::word_t wData;	// Store data
	exPkg::word_t rData;	// Load data, valid on DONE
	memPkg::memOk_t ok;	// Access status

	// Requester side drives the access fields
	modport requester(output req, we, addr, wData, input rData, ok);

	// Arbiter side answers with data and status
	modport arbiter(input req, we, addr, wData, output rData, ok);

endinterface

`default_nettype wire

//--- mulUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mulUnit (
	input wire clock,
	input wire [31:0] srcA,	// Multiplicand
	input wire [31:0] srcB,	// Multiplier
	input wire isUnsigned,	// Zero-extend both sources
	output logic [63:0] product	// Valid 3 cycles after sources
);

	logic signed [32:0] aQ;	// Stage 1 operands, 33 bits cover both signs
	logic signed [32:0] bQ;
	logic signed [65:0] prodQ;	// Stage 2 full product

	always_ff @(posedge clock) begin
		aQ <= {srcA[31] & !isUnsigned, srcA};
		bQ <= {srcB[31] & !isUnsigned, srcB};
		prodQ <= aQ * bQ;
		product <= prodQ[63:0];	// Low 64 bits are exact either way
	end

endmodule

`default_nettype wire

//--- dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam #(
	parameter int unsigned memWords = 1024
) (
	input wire clock,
	input wire ramReq,
	input wire ramWe,
	input wire memPkg::memAddr_t ramAddr,
	input wire exPkg::word_t ramWData,
	output exPkg::word_t ramRData,
	output memPkg::memOk_t ramOk
);

	localparam int idxW = $clog2(memWords);

	typedef enum logic [1:0] {IDLE, RESP, WAIT} ramState_t;

	ramState_t state;
	exPkg::word_t mem [memWords];
	logic inRange;

	assign inRange = ramAddr < memWords;

	always_comb begin
		case (state)
			IDLE: ramOk = ramReq ? memPkg::HOLD : memPkg::READY;	// First request cycle
			RESP: ramOk = inRange ? memPkg::DONE : memPkg::FAULT;
			default: ramOk = memPkg::READY;	// Turnaround before next request
		endcase
	end

	always_ff @(posedge clock) begin
		case (state)
			IDLE: if (ramReq) begin
				state <= RESP;
				ramRData <= mem[ramAddr[idxW-1:0]];	// Synchronous read
			end
			RESP: begin
				state <= WAIT;
				if (ramWe && inRange)
					mem[ramAddr[idxW-1:0]] <= ramWData;
			end
			default: state <= IDLE;	// Settles to IDLE from any state
		endcase
	end

endmodule

`default_nettype wire

//--- memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter #(
	parameter int unsigned memWords = 1024
) (
	input wire clock,
	input wire rst,
	memBusIf.arbiter exBus,	// EX2 stage port
	memBusIf.arbiter dbgBus,	// Debug port
	output logic ramReq,
	output logic ramWe,
	output memPkg::memAddr_t ramAddr,
	output exPkg::word_t ramWData,
	input wire exPkg::word_t ramRData,
	input wire memPkg::memOk_t ramOk
);

	typedef enum logic {IDLE, BUSY} arbState_t;

	arbState_t state;
	logic grantDbg;	// Current owner is the debug port
	logic lastDbg;	// Debug port won the last grant
	logic pickDbg;	// Winner if a grant happens now
	logic ramEnd;	// RAM reports DONE or FAULT

	always_comb begin
		pickDbg = dbgBus.req && (!exBus.req || !lastDbg);	// Alternate on contention
		ramEnd = (ramOk == memPkg::DONE) || (ramOk == memPkg::FAULT);
		ramReq = (state == BUSY);
		ramAddr = grantDbg ? dbgBus.addr : exBus.addr;
		ramWData = grantDbg ? dbgBus.wData : exBus.wData;
		ramWe = (grantDbg ? dbgBus.we : exBus.we) && (ramAddr < memWords);	// Write guard
		exBus.ok = exBus.req ? memPkg::HOLD : memPkg::READY;	// Waiting port sees HOLD
		dbgBus.ok = dbgBus.req ? memPkg::HOLD : memPkg::READY;
		if (state == BUSY) begin
			if (grantDbg)
				dbgBus.ok = ramOk;
			else
				exBus.ok = ramOk;
		end
	end

	assign exBus.rData = ramRData;	// Only meaningful on DONE
	assign dbgBus.rData = ramRData;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
			grantDbg <= 1'b0;
			lastDbg <= 1'b1;	// First contended grant goes to EX2
		end else begin
			case (state)
				IDLE: if (exBus.req || dbgBus.req) begin
					state <= BUSY;
					grantDbg <= pickDbg;
					lastDbg <= pickDbg;
				end
				default: if (ramEnd)
					state <= IDLE;	// Grant held for the whole access
			endcase
		end
	end

endmodule

`default_nettype wire

//--- exStage2.sv
`timescale 1ns/1ps
`default_nettype none

module exStage2 (
	input wire clock,
	input wire rst,
	input wire [7:0] opUCmd,	// Predicate in 7:6, command in 5:0
	input wire [7:0] opUIxt,	// Sub-op selector
	input wire opBraFlush,	// Squash from branch
	input wire exPkg::regId_t regIdRm,	// Dest for ALU/MUL/load
	input wire exPkg::word_t regValRm,	// Store data
	input wire exPkg::word_t regValRs,	// Source A value
	input wire exPkg::word_t regValRt,	// Source B value
	input wire exPkg::regId_t regIdRn1,	// EX1 destination
	input wire exPkg::word_t regValRn1,
	input wire exPkg::aluRes_t regValAluRes,
	input wire exPkg::word_t regValMulRes,
	input wire memPkg::memAddr_t memAddr,	// Effective address from EX1
	input wire exPkg::word_t regInDlr,
	input wire exPkg::word_t regInDhr,
	input wire exPkg::word_t regInSr,
	output logic exHold,
	output logic exFault,
	output exPkg::regId_t regIdRn2,
	output exPkg::word_t regValRn2,
	output exPkg::word_t regOutDlr,
	output exPkg::word_t regOutDhr,
	output exPkg::word_t regOutSr,
	memBusIf.requester bus
);

	exPkg::uCmd_t cmd;	// Command after predication
	logic opEnable;
	logic memOp;	// Load or store in flight
	logic memEnd;	// Bus reports DONE or FAULT
	logic [1:0] holdCyc;	// Cycles spent in hold

	// Predicate against SR.T, flush overrides
	always_comb begin
		case (exPkg::predMode_t'(opUCmd[7:6]))
			exPkg::ALWAYS: opEnable = 1'b1;
			exPkg::NEVER: opEnable = 1'b0;
			exPkg::IF_T: opEnable = regInSr[0];
			default: opEnable = !regInSr[0];	// IF_F
		endcase
		if (opBraFlush)
			opEnable = 1'b0;
		cmd = opEnable ? exPkg::uCmd_t'(opUCmd[5:0]) : exPkg::NOP;
	end

	always_comb begin
		regIdRn2 = regIdRn1;	// Forward by default
		regValRn2 = regValRn1;
		regOutDlr = regInDlr;
		regOutDhr = regInDhr;
		regOutSr = regInSr;
		exHold = 1'b0;
		exFault = 1'b0;
		memOp = 1'b0;
		bus.we = 1'b0;
		memEnd = (bus.ok == memPkg::DONE) || (bus.ok == memPkg::FAULT);

		case (cmd)
			exPkg::MOV_RM: begin
				memOp = 1'b1;
				bus.we = 1'b1;
			end
			exPkg::MOV_MR: begin
				memOp = 1'b1;
				if (bus.ok == memPkg::DONE) begin	// Fault leaves Rn1 forwarded
					regIdRn2 = regIdRm;
					regValRn2 = bus.rData;
				end
			end
			exPkg::ALU3: begin
				regIdRn2 = regIdRm;
				regValRn2 = regValAluRes[63:0];
				regOutSr[1:0] = regValAluRes[65:64];	// S and T flags
			end
			exPkg::ALUCMP: begin
				regOutSr[1:0] = regValAluRes[65:64];
			end
			exPkg::MUL3: begin
				if (holdCyc != 2'd3)
					exHold = 1'b1;	// Wait out the multiplier pipe
				case (opUIxt[1:0])
					2'b00: begin
						regIdRn2 = regIdRm;
						regValRn2 = {{32{regValMulRes[31]}}, regValMulRes[31:0]};
					end
					2'b01: begin
						regIdRn2 = regIdRm;
						regValRn2 = {32'd0, regValMulRes[31:0]};
					end
					2'b10: begin
						regOutDlr = {32'd0, regValMulRes[31:0]};
						regOutDhr = {{32{regValMulRes[63]}}, regValMulRes[63:32]};
					end
					default: begin	// Both halves unsigned
						regOutDlr = {32'd0, regValMulRes[31:0]};
						regOutDhr = {32'd0, regValMulRes[63:32]};
					end
				endcase
			end
			default: begin	// Unhandled commands act as NOP
			end
		endcase

		if (memOp) begin
			exHold = !memEnd;	// Stall until the bus finishes
			exFault = (bus.ok == memPkg::FAULT);	// Only for the faulting cycle
		end
	end

	assign bus.req = memOp;	// Held while EX1 holds the op
	assign bus.addr = memAddr;
	assign bus.wData = regValRm;

	always_ff @(posedge clock) begin
		if (rst)
			holdCyc <= 2'd0;
		else if (exHold)
			holdCyc <= holdCyc + 2'd1;
		else
			holdCyc <= 2'd0;	// Each op starts from zero
	end

endmodule

`default_nettype wire

//--- exCore.sv
`timescale 1ns/1ps
`default_nettype none

module exCore #(
	parameter int unsigned memWords = 1024
) (
	input wire clock,
	input wire rst,
	input wire [7:0] opUCmd,
	input wire [7:0] opUIxt,
	input wire opBraFlush,
	input wire exPkg::regId_t regIdRm,
	input wire exPkg::word_t regValRm,
	input wire exPkg::word_t regValRs,
	input wire exPkg::word_t regValRt,
	input wire exPkg::regId_t regIdRn1,
	input wire exPkg::word_t regValRn1,
	input wire exPkg::aluRes_t regValAluRes,
	input wire memPkg::memAddr_t memAddr,
	input wire exPkg::word_t regInDlr,
	input wire exPkg::word_t regInDhr,
	input wire exPkg::word_t regInSr,
	output logic exHold,
	output logic exFault,
	output exPkg::regId_t regIdRn2,
	output exPkg::word_t regValRn2,
	output exPkg::word_t regOutDlr,
	output exPkg::word_t regOutDhr,
	output exPkg::word_t regOutSr,
	input wire dbgReq,	// Debug access, held until dbgDone
	input wire dbgWe,
	input wire memPkg::memAddr_t dbgAddr,
	input wire exPkg::word_t dbgWData,
	output exPkg::word_t dbgRData,
	output logic dbgDone
);

	exPkg::word_t mulRes;
	logic ramReq;
	logic ramWe;
	memPkg::memAddr_t ramAddr;
	exPkg::word_t ramWData;
	exPkg::word_t ramRData;
	memPkg::memOk_t ramOk;

	memBusIf exBus ();
	memBusIf dbgBus ();

	assign dbgBus.req = dbgReq;	// Debug port maps straight onto its bus
	assign dbgBus.we = dbgWe;
	assign dbgBus.addr = dbgAddr;
	assign dbgBus.wData = dbgWData;
	assign dbgRData = dbgBus.rData;
	assign dbgDone = (dbgBus.ok == memPkg::DONE);

	exStage2 u_exStage2 (
		.clock, .rst, .opUCmd, .opUIxt, .opBraFlush,
		.regIdRm, .regValRm, .regValRs, .regValRt,
		.regIdRn1, .regValRn1, .regValAluRes,
		.regValMulRes(mulRes), .memAddr,
		.regInDlr, .regInDhr, .regInSr,
		.exHold, .exFault, .regIdRn2, .regValRn2,
		.regOutDlr, .regOutDhr, .regOutSr,
		.bus(exBus.requester)
	);

	// Runs every cycle, EX2 picks the product up after its hold
	mulUnit u_mulUnit (
		.clock,
		.srcA(regValRs[31:0]),
		.srcB(regValRt[31:0]),
		.isUnsigned(opUIxt[0]),
		.product(mulRes)
	);

	memArbiter #(.memWords(memWords)) u_memArbiter (
		.clock, .rst,
		.exBus(exBus.arbiter),
		.dbgBus(dbgBus.arbiter),
		.ramReq, .ramWe, .ramAddr, .ramWData, .ramRData, .ramOk
	);

	dataRam #(.memWords(memWords)) u_dataRam (
		.clock, .ramReq, .ramWe, .ramAddr, .ramWData, .ramRData, .ramOk
	);

endmodule

`default_nettype wire

//--- exTb_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module busChecks (
	input wire clock,
	input wire rst,
	input wire hold,	// Must read low right after reset
	input wire stallReq,	// Request pending with status HOLD
	input wire [15:0] addr,
	input wire [63:0] data,
	input wire memPkg::memOk_t okA,
	input wire memPkg::memOk_t okB	// Never DONE together with okA
);

	holdAfterReset: assert property (@(posedge clock) rst |=> !hold)
		else $error("hold high right after reset");

	// Address and data frozen while waiting
	fieldsStable: assert property (@(posedge clock) disable iff (rst)
		stallReq |=> ($stable(addr) && $stable(data)))
		else $error("bus fields changed during HOLD");

	singleDone: assert property (@(posedge clock) disable iff (rst)
		!(okA == memPkg::DONE && okB == memPkg::DONE))
		else $error("DONE seen on both inputs in the same cycle");

endmodule

// Stage hold has to drop in the DONE cycle
bind exStage2 busChecks u_stageChecks (
	.clock, .rst, .hold(exHold), .stallReq(memOp && !memEnd),
	.addr(memAddr), .data(regValRm), .okA(bus.ok),
	.okB(exHold ? memPkg::DONE : memPkg::READY)
);

bind memArbiter busChecks u_arbChecks (
	.clock, .rst, .hold(ramReq), .stallReq(state == BUSY && ramOk == memPkg::HOLD),
	.addr(ramAddr), .data(ramWData), .okA(exBus.ok), .okB(dbgBus.ok)
);

`default_nettype wire

//--- exTb.sv
`timescale 1ns/1ps
`default_nettype none

module exTb;

	localparam int maxOps = 64;
	localparam int rstCycles = 8;

	logic clock;
	logic rst;
	logic [7:0] opUCmd;
	logic [7:0] opUIxt;
	logic opBraFlush;
	exPkg::regId_t regIdRm, regIdRn1, regIdRn2;
	exPkg::word_t regValRm, regValRs, regValRt, regValRn1, regValRn2;
	exPkg::aluRes_t regValAluRes;
	memPkg::memAddr_t memAddr, dbgAddr;
	exPkg::word_t regInDlr, regInDhr, regInSr, regOutDlr, regOutDhr, regOutSr;
	exPkg::word_t dbgWData, dbgRData;
	logic exHold, exFault, dbgReq, dbgWe, dbgDone;

	// One trace line per op
	string tName [maxOps];
	logic [7:0] tCmd [maxOps], tIxt [maxOps];
	logic tFlush [maxOps], tCont [maxOps], tFault [maxOps];
	logic [5:0] tRm [maxOps], tRn1 [maxOps], tId [maxOps];
	logic [63:0] tValRm [maxOps], tRs [maxOps], tRt [maxOps], tValRn1 [maxOps];
	logic [65:0] tAlu [maxOps];
	logic [15:0] tAddr [maxOps];
	logic [63:0] tDlr [maxOps], tDhr [maxOps], tSr [maxOps];
	logic [63:0] tVal [maxOps], tOutDlr [maxOps], tOutDhr [maxOps], tOutSr [maxOps];
	int opCount;
	int cycleCount;
	int cycleLimit;
	logic [63:0] shadow [int];	// Every completed store
	memPkg::memAddr_t written [$];

	exCore u_exCore (.*);

	always #20 clock = ~clock;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input string test, input string field,
			input logic [63:0] expVal, input logic [63:0] actVal);
		if (expVal !== actVal) begin
			$display("FAIL %s %s expected %h actual %h", test, field, expVal, actVal);
			failRun("value mismatch");
		end
	endtask

	// Hold length from the stage rules, predicate against SR.T
	function automatic int expectedHold(input int i);
		logic en;
		case (tCmd[i][7:6])
			2'b00: en = 1'b1;
			2'b01: en = 1'b0;
			2'b10: en = tSr[i][0];
			default: en = !tSr[i][0];
		endcase
		if (!en || tFlush[i])
			return 0;
		if (tCmd[i][5:0] == 6'h05)
			return 3;
		if (tCmd[i][5:0] == 6'h01 || tCmd[i][5:0] == 6'h02)
			return 2;
		return 0;
	endfunction

	task automatic runOp(input int i);
		int holdCount;
		holdCount = 0;
		{opUCmd, opUIxt, opBraFlush} = {tCmd[i], tIxt[i], tFlush[i]};
		{regIdRm, regValRm, regValRs, regValRt} = {tRm[i], tValRm[i], tRs[i], tRt[i]};
		{regIdRn1, regValRn1, regValAluRes, memAddr} = {tRn1[i], tValRn1[i], tAlu[i], tAddr[i]};
		{regInDlr, regInDhr, regInSr} = {tDlr[i], tDhr[i], tSr[i]};
		#5;
		while (exHold) begin	// EX1 keeps the op steady
			holdCount++;
			@(negedge clock);
			#5;
		end
		checkValue(tName[i], "regIdRn2", 64'(tId[i]), 64'(regIdRn2));
		checkValue(tName[i], "regValRn2", tVal[i], regValRn2);
		checkValue(tName[i], "regOutDlr", tOutDlr[i], regOutDlr);
		checkValue(tName[i], "regOutDhr", tOutDhr[i], regOutDhr);
		checkValue(tName[i], "regOutSr", tOutSr[i], regOutSr);
		checkValue(tName[i], "exFault", 64'(tFault[i]), 64'(exFault));
		if (!tCont[i])	// Contended latency varies
			checkValue(tName[i], "holdCycles", 64'(expectedHold(i)), 64'(holdCount));
		if (tCmd[i] == 8'h01 && !tFlush[i] && !tFault[i]) begin
			shadow[tAddr[i]] = tValRm[i];
			written.push_back(tAddr[i]);
		end
		@(negedge clock);
		opUCmd = 8'h00;
	endtask

	task automatic debugRead(input string test);
		memPkg::memAddr_t a;
		if (written.size() == 0)
			failRun("debug read requested before any store");
		a = written[$urandom % written.size()];
		{dbgAddr, dbgWe, dbgReq} = {a, 1'b0, 1'b1};
		#5;
		while (!dbgDone) begin
			@(negedge clock);
			#5;
		end
		checkValue(test, "dbgRData", shadow[a], dbgRData);
		@(negedge clock);
		dbgReq = 1'b0;
	endtask

	always @(posedge clock) begin
		cycleCount++;
		if (cycleLimit != 0 && cycleCount > cycleLimit)
			failRun("timeout, the DUT did not finish the trace in time");
	end

	initial begin
		int fd;
		string line;
		void'($urandom(32'h724f));
		{clock, rst, opUCmd, opUIxt, opBraFlush, regIdRm, regValRm} = '0;
		{regValRs, regValRt, regIdRn1, regValRn1, regValAluRes, memAddr} = '0;
		{regInDlr, regInDhr, regInSr, dbgReq, dbgWe, dbgAddr, dbgWData} = '0;
		rst = 1'b1;
		cycleCount = 0;
		cycleLimit = 0;
		opCount = 0;
		fd = $fopen("ex_trace.txt", "r");
		if (fd == 0)
			failRun("cannot open ex_trace.txt");
		while (!$feof(fd) && opCount < maxOps) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 3 || line[0] == "#")
				continue;	// Column header or blank
			if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					tName[opCount], tCmd[opCount], tIxt[opCount], tFlush[opCount],
					tRm[opCount], tValRm[opCount], tRs[opCount], tRt[opCount],
					tRn1[opCount], tValRn1[opCount], tAlu[opCount], tAddr[opCount],
					tDlr[opCount], tDhr[opCount], tSr[opCount], tCont[opCount],
					tId[opCount], tVal[opCount], tOutDlr[opCount], tOutDhr[opCount],
					tOutSr[opCount], tFault[opCount]) != 22)
				failRun("malformed line in ex_trace.txt");
			opCount++;
		end
		$fclose(fd);
		cycleLimit = opCount * 12 + rstCycles;
		repeat (rstCycles) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		for (int i = 0; i < opCount; i++) begin
			@(negedge clock);
			fork
				runOp(i);
				if (tCont[i])
					debugRead(tName[i]);	// Same cycle as the op
			join
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- ex_trace.txt
# name cmd ixt flush rm valRm rs rt rn1 valRn1 alu addr dlr dhr sr cont
#   then expected: rn2Id rn2Val dlr dhr sr fault (all hex)
alu3 03 00 0 05 0 0 0 07 abc 20000000000001234 0 11 22 0 0 05 1234 11 22 2 0
alucmp 04 00 0 05 0 0 0 07 abc 10000000000000055 0 11 22 f0 0 07 abc 11 22 f1 0
predT_on 83 00 0 05 0 0 0 07 abc 42 0 11 22 1 0 05 42 11 22 0 0
predT_off 83 00 0 05 0 0 0 07 abc 42 0 11 22 0 0 07 abc 11 22 0 0
predF_on c3 00 0 05 0 0 0 07 abc 30000000000000099 0 11 22 0 0 05 99 11 22 3 0
never 43 00 0 05 0 0 0 07 abc 42 0 11 22 1 0 07 abc 11 22 1 0
flush 03 00 1 05 0 0 0 07 abc 42 0 11 22 4 0 07 abc 11 22 4 0
mul_s 05 00 0 05 0 fffffffe 3 07 abc 0 0 11 22 0 0 05 fffffffffffffffa 11 22 0 0
mul_u 05 01 0 05 0 fffffffe 3 07 abc 0 0 11 22 0 0 05 fffffffa 11 22 0 0
mul_dsig 05 02 0 05 0 fffffffe 3 07 abc 0 0 11 22 0 0 07 abc fffffffa ffffffffffffffff 0 0
mul_duns 05 03 0 05 0 fffffffe 3 07 abc 0 0 11 22 0 0 07 abc fffffffa 2 0 0
store1 01 00 0 05 deadbeef12345678 0 0 07 abc 0 10 11 22 0 0 07 abc 11 22 0 0
store2 01 00 0 06 cafe 0 0 07 abc 0 20 11 22 0 0 07 abc 11 22 0 0
load1 02 00 0 09 0 0 0 07 abc 0 10 11 22 0 0 09 deadbeef12345678 11 22 0 0
load_cont 02 00 0 0a 0 0 0 07 abc 0 20 11 22 0 1 0a cafe 11 22 0 0
load_cont2 02 00 0 0b 0 0 0 07 abc 0 10 11 22 0 1 0b deadbeef12345678 11 22 0 0
load_oob 02 00 0 0c 0 0 0 07 abc 0 500 11 22 0 0 07 abc 11 22 0 1
load_flush 02 00 1 0d 0 0 0 07 abc 0 10 11 22 0 0 07 abc 11 22 0 0

//--- sim.f
exPkg.sv
memPkg.sv
memBusIf.sv
mulUnit.sv
dataRam.sv
memArbiter.sv
exStage2.sv
exCore.sv
exTb_assertions.sv
exTb.sv

//--- Makefile
SIM = obj_dir/exTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the trace testbench"
	@echo "make clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module exTb -f sim.f -o exTb
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
